// File: src/fds_pkg.sv
// FDS mapper definitions

package fds_pkg;

	typedef logic [15:0] cpu_addr_t;
	typedef logic [7:0]  byte_t;
	typedef logic [21:0] mem_addr_t;
	typedef logic [15:0] disk_pos_t;
	typedef logic [1:0]  side_t;
	typedef logic [15:0] timer_t;
	typedef logic [19:0] xfer_cnt_t;
	typedef logic [22:0] eject_cnt_t;

	// Type of the block currently passing under the head
	typedef enum logic [2:0] {
		BLK_NONE        = 3'd0,
		BLK_DISK_INFO   = 3'd1,
		BLK_FILE_AMOUNT = 3'd2,
		BLK_FILE_HEADER = 3'd3,
		BLK_FILE_DATA   = 3'd4
	} block_type_e;

	// Register map
	localparam cpu_addr_t REG_TIMER_LO     = 16'h4020;
	localparam cpu_addr_t REG_TIMER_HI     = 16'h4021;
	localparam cpu_addr_t REG_TIMER_CTRL   = 16'h4022;
	localparam cpu_addr_t REG_IO_EN        = 16'h4023;
	localparam cpu_addr_t REG_DISK_CTRL    = 16'h4025;
	localparam cpu_addr_t REG_STATUS       = 16'h4030;
	localparam cpu_addr_t REG_DISK_DATA    = 16'h4031;
	localparam cpu_addr_t REG_DRIVE_STATUS = 16'h4032;
	localparam cpu_addr_t REG_EXT_PORT     = 16'h4033;

	// Bit positions in $4022 and $4025
	localparam int TIMER_REPEAT_BIT = 0;
	localparam int TIMER_EN_BIT     = 1;
	localparam int CTRL_MOTOR_BIT   = 0;
	localparam int CTRL_REWIND_BIT  = 1;
	localparam int CTRL_XFER_BIT    = 6;
	localparam int CTRL_IRQ_BIT     = 7;

	// Real drive is about 149 CPU cycles per byte, fast mode shortens it
	localparam xfer_cnt_t  PRE_GAP_FAST    = 20'd65535;
	localparam xfer_cnt_t  PRE_GAP_ORIG    = 20'd525420;
	localparam xfer_cnt_t  BYTE_DELAY_FAST = 20'd99;
	localparam xfer_cnt_t  BYTE_DELAY_ORIG = 20'd149;
	localparam eject_cnt_t EJECT_DELAY     = 23'd2978000; // About 100 frames

	// Side n of the image starts at 16 + 65500 * n
	localparam int unsigned SIDE_BYTES      = 65500;
	localparam int unsigned SIDE_HEADER     = 16;
	localparam disk_pos_t   DISK_END_POS    = 16'd65499;
	localparam logic [3:0]  DISK_IMAGE_BASE = 4'hF;

	// Last byte index of the fixed-size blocks
	localparam disk_pos_t INFO_LAST   = 16'h0037;
	localparam disk_pos_t AMOUNT_LAST = 16'h0001;
	localparam disk_pos_t HEADER_LAST = 16'h000F;
	localparam disk_pos_t SIZE_LO_IDX = 16'h000D;
	localparam disk_pos_t SIZE_HI_IDX = 16'h000E;

endpackage

// File: src/fds_cpu_regs.sv
// FDS register decode

`timescale 1ns/1ps

module fds_cpu_regs (
	input  logic              clk,
	input  logic              diskreset,
	input  logic              ce,
	input  logic              prg_read,
	input  logic              prg_write,
	input  fds_pkg::cpu_addr_t prg_ain,
	input  fds_pkg::byte_t    prg_din,
	input  logic              timer_irq,
	input  logic              byte_flag,
	input  logic              disk_end,
	input  logic              eject,
	input  logic              disk_ready,
	input  fds_pkg::disk_pos_t disk_pos,
	input  fds_pkg::side_t    diskside,
	output logic              timer_lo_wr,
	output logic              timer_hi_wr,
	output logic              timer_ctrl_wr,
	output logic              io_en_wr,
	output logic              status_rd,
	output logic              disk_rd,
	output logic              xfer_start,
	output logic              motor_on,
	output logic              head_rewind,
	output logic              byte_transfer,
	output logic              disk_irq_en,
	output fds_pkg::byte_t    wdata,
	output fds_pkg::byte_t    prg_dout,
	output fds_pkg::mem_addr_t prg_aout,
	output logic              prg_allow,
	output logic              prg_bus_write
);

	logic        wr_cyc, rd_cyc;
	logic        ctrl_wr;
	logic        disk_sel;
	logic        prg_is_ram;
	logic [5:0]  prg_bank;
	logic [17:0] side_offset;
	logic [17:0] rom_offset;

	assign wr_cyc = ce & prg_write;
	assign rd_cyc = ce & prg_read;

	assign timer_lo_wr   = wr_cyc & (prg_ain == fds_pkg::REG_TIMER_LO);
	assign timer_hi_wr   = wr_cyc & (prg_ain == fds_pkg::REG_TIMER_HI);
	assign timer_ctrl_wr = wr_cyc & (prg_ain == fds_pkg::REG_TIMER_CTRL);
	assign io_en_wr      = wr_cyc & (prg_ain == fds_pkg::REG_IO_EN);
	assign ctrl_wr       = wr_cyc & (prg_ain == fds_pkg::REG_DISK_CTRL);
	assign status_rd     = rd_cyc & (prg_ain == fds_pkg::REG_STATUS);
	assign disk_rd       = rd_cyc & disk_sel;
	assign wdata         = prg_din;

	// Transfer bit going from 0 to 1 starts a new block
	assign xfer_start = ctrl_wr & ~byte_transfer & prg_din[fds_pkg::CTRL_XFER_BIT];

	always_ff @(posedge clk) begin
		if (diskreset) begin
			motor_on      <= 1'b0;
			head_rewind   <= 1'b0;
			byte_transfer <= 1'b0;
			disk_irq_en   <= 1'b0;
		end else if (ctrl_wr) begin
			motor_on      <= prg_din[fds_pkg::CTRL_MOTOR_BIT];
			head_rewind   <= prg_din[fds_pkg::CTRL_REWIND_BIT];
			byte_transfer <= prg_din[fds_pkg::CTRL_XFER_BIT];
			disk_irq_en   <= prg_din[fds_pkg::CTRL_IRQ_BIT];
		end
	end

	// Status readback
	always_comb begin
		prg_bus_write = 1'b1;
		case (prg_ain)
			fds_pkg::REG_STATUS:       prg_dout = {byte_flag, disk_end, 5'd0, timer_irq};
			fds_pkg::REG_DRIVE_STATUS: prg_dout = {4'h4, 1'b0, eject, ~disk_ready, eject};
			fds_pkg::REG_EXT_PORT:     prg_dout = 8'h80; // Battery good
			fds_pkg::REG_DISK_DATA:    prg_dout = 8'h00; // Byte comes from the image
			default: begin
				prg_dout      = 8'h00;
				prg_bus_write = 1'b0;
			end
		endcase
	end

	assign disk_sel = (prg_ain == fds_pkg::REG_DISK_DATA);

	// Side offset is 16 + 65500 * side
	assign side_offset = 18'(fds_pkg::SIDE_HEADER + fds_pkg::SIDE_BYTES * diskside);
	assign rom_offset  = 18'(disk_pos) + side_offset;

	// $6000-$DFFF is work RAM, $E000-$FFFF is BIOS bank 0
	assign prg_is_ram = prg_ain[15] ^ (&prg_ain[14:13]);
	assign prg_bank   = prg_is_ram ? {4'b0001, prg_ain[14:13]} : 6'd0;

	assign prg_aout  = disk_sel ? {fds_pkg::DISK_IMAGE_BASE, rom_offset}
	                            : {3'b000, prg_bank, prg_ain[12:0]};
	assign prg_allow = ((prg_ain[15] | disk_sel) & ~prg_write) | prg_is_ram;

endmodule

// File: src/fds_timer_irq.sv
// FDS timer IRQ

`timescale 1ns/1ps

module fds_timer_irq (
	input  logic           clk,
	input  logic           diskreset,
	input  logic           ce,
	input  logic           timer_lo_wr,
	input  logic           timer_hi_wr,
	input  logic           timer_ctrl_wr,
	input  logic           io_en_wr,
	input  logic           status_rd,
	input  fds_pkg::byte_t wdata,
	output logic           timer_irq
);

	fds_pkg::timer_t reload;
	fds_pkg::timer_t count;
	logic            repeat_en;
	logic            timer_en;
	logic            io_en;
	logic            rd_pending; // $4030 read waiting for the next strobe

	always_ff @(posedge clk) begin
		if (diskreset) begin
			timer_irq  <= 1'b0;
			timer_en   <= 1'b0;
			repeat_en  <= 1'b0;
			io_en      <= 1'b0;
			rd_pending <= 1'b0;
		end else if (ce) begin
			if (timer_en) begin
				if (count == '0) begin
					timer_irq <= 1'b1;
					count     <= reload;
					if (~repeat_en)
						timer_en <= 1'b0; // One shot
				end else begin
					count <= count - 1'b1;
				end
			end

			if (rd_pending) begin
				timer_irq  <= 1'b0;
				rd_pending <= 1'b0;
			end
			if (status_rd)
				rd_pending <= 1'b1;

			if (timer_lo_wr)
				reload[7:0] <= wdata;
			if (timer_hi_wr)
				reload[15:8] <= wdata;

			if (timer_ctrl_wr) begin
				repeat_en <= wdata[fds_pkg::TIMER_REPEAT_BIT];
				timer_en  <= wdata[fds_pkg::TIMER_EN_BIT] & io_en;
				if (wdata[fds_pkg::TIMER_EN_BIT] & io_en)
					count <= reload;
				else
					timer_irq <= 1'b0;
			end

			if (io_en_wr) begin
				io_en <= wdata[0];
				if (~wdata[0]) begin // Disabling I/O kills the timer
					timer_en  <= 1'b0;
					timer_irq <= 1'b0;
				end
			end
		end
	end

endmodule

// File: src/fds_disk_drive.sv
// FDS drive read path

`timescale 1ns/1ps

module fds_disk_drive (
	input  logic               clk,
	input  logic               diskreset,
	input  logic               ce,
	input  logic               motor_on,
	input  logic               head_rewind,
	input  logic               byte_transfer,
	input  logic               disk_irq_en,
	input  logic               xfer_start,
	input  logic               disk_rd,
	input  logic               status_rd,
	input  logic               block_end,
	input  logic               fds_busy,
	input  logic               fds_fast,
	input  logic               fds_eject_btn,
	input  fds_pkg::side_t     max_diskside,
	output logic               byte_flag,
	output logic               byte_step,
	output logic               disk_end,
	output logic               disk_ready,
	output logic               eject,
	output logic               disk_irq,
	output fds_pkg::disk_pos_t disk_pos,
	output fds_pkg::side_t     diskside
);

	fds_pkg::xfer_cnt_t  xfer_cnt;
	fds_pkg::xfer_cnt_t  pre_gap;
	fds_pkg::xfer_cnt_t  byte_delay;
	fds_pkg::eject_cnt_t eject_cnt;
	logic after_pre_gap;
	logic new_byte;   // Byte under the head not yet consumed
	logic read_d;
	logic rd_pending;
	logic eject_hold;
	logic old_btn;

	assign pre_gap    = fds_fast ? fds_pkg::PRE_GAP_FAST : fds_pkg::PRE_GAP_ORIG;
	assign byte_delay = fds_fast ? fds_pkg::BYTE_DELAY_FAST : fds_pkg::BYTE_DELAY_ORIG;

	assign disk_end   = (disk_pos == fds_pkg::DISK_END_POS);
	assign eject      = eject_hold | fds_eject_btn;
	assign disk_ready = ~eject & ~head_rewind & motor_on & ~disk_end;
	assign disk_irq   = byte_flag & disk_irq_en;
	assign byte_step  = ce & read_d & new_byte; // Counted one strobe after the $4031 read

	always_ff @(posedge clk) begin
		if (diskreset) begin
			xfer_cnt      <= '0;
			after_pre_gap <= 1'b0;
			new_byte      <= 1'b0;
			byte_flag     <= 1'b0;
			read_d        <= 1'b0;
			rd_pending    <= 1'b0;
			disk_pos      <= '0;
			diskside      <= '0;
			eject_hold    <= 1'b0;
			eject_cnt     <= '0;
			old_btn       <= 1'b0;
		end else if (ce) begin
			read_d <= disk_rd;

			if (rd_pending) begin
				byte_flag  <= 1'b0;
				rd_pending <= 1'b0;
			end
			if (status_rd)
				rd_pending <= 1'b1;

			if (read_d & new_byte) begin
				new_byte  <= 1'b0;
				byte_flag <= 1'b0;
				if (~disk_end & ~block_end)
					disk_pos <= disk_pos + 1'b1;
			end

			// Head timing
			if (~motor_on) begin
				xfer_cnt <= '0;
			end else if (head_rewind) begin
				xfer_cnt      <= '0;
				disk_pos      <= '0;
				after_pre_gap <= 1'b0;
			end else if (~after_pre_gap) begin
				xfer_cnt <= xfer_cnt + 1'b1;
				if (xfer_cnt == pre_gap) begin // Start of the disk reached
					after_pre_gap <= 1'b1;
					xfer_cnt      <= '0;
				end
			end else if (xfer_cnt == byte_delay) begin
				xfer_cnt <= '0;
				if (byte_transfer & ~fds_busy) begin
					byte_flag <= 1'b1;
					new_byte  <= 1'b1;
				end
			end else begin
				xfer_cnt <= xfer_cnt + 1'b1;
			end

			if (xfer_start) begin
				byte_flag <= 1'b0;
				new_byte  <= 1'b0;
				if (after_pre_gap)
					xfer_cnt <= '0;
			end

			// Manual side switch
			old_btn <= fds_eject_btn;
			if (eject_hold) begin
				if (eject_cnt == fds_pkg::EJECT_DELAY - 1'b1)
					eject_hold <= 1'b0;
				else
					eject_cnt <= eject_cnt + 1'b1;
			end
			if (~old_btn & fds_eject_btn & ~fds_busy) begin
				diskside   <= (diskside == max_diskside) ? '0 : diskside + 1'b1;
				eject_hold <= 1'b1;
				eject_cnt  <= '0;
			end
		end
	end

endmodule

// File: src/fds_block_tracker.sv
// FDS block end tracker

`timescale 1ns/1ps

module fds_block_tracker (
	input  logic           clk,
	input  logic           diskreset,
	input  logic           ce,
	input  logic           xfer_start,
	input  logic           disk_rd,
	input  logic           byte_step,
	input  fds_pkg::byte_t prg_dbus,
	output logic           block_end
);

	fds_pkg::block_type_e block_type;
	fds_pkg::block_type_e type_in;
	fds_pkg::disk_pos_t   byte_cnt;
	fds_pkg::disk_pos_t   file_size;
	logic                 last_byte;

	// Block code in the first byte of each block
	always_comb begin
		case (prg_dbus[2:0])
			3'd1:    type_in = fds_pkg::BLK_DISK_INFO;
			3'd2:    type_in = fds_pkg::BLK_FILE_AMOUNT;
			3'd3:    type_in = fds_pkg::BLK_FILE_HEADER;
			3'd4:    type_in = fds_pkg::BLK_FILE_DATA;
			default: type_in = fds_pkg::BLK_NONE;
		endcase
	end

	// .fds images carry no CRC bytes, so the end has to be found by length
	always_comb begin
		case (block_type)
			fds_pkg::BLK_DISK_INFO:   last_byte = (byte_cnt == fds_pkg::INFO_LAST);
			fds_pkg::BLK_FILE_AMOUNT: last_byte = (byte_cnt == fds_pkg::AMOUNT_LAST);
			fds_pkg::BLK_FILE_HEADER: last_byte = (byte_cnt == fds_pkg::HEADER_LAST);
			fds_pkg::BLK_FILE_DATA:   last_byte = (byte_cnt == file_size);
			default:                  last_byte = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (diskreset) begin
			block_type <= fds_pkg::BLK_NONE;
			byte_cnt   <= '0;
			block_end  <= 1'b0;
		end else if (ce) begin
			if (xfer_start) begin
				block_type <= fds_pkg::BLK_NONE;
				byte_cnt   <= '0;
				block_end  <= 1'b0;
			end else begin
				if (disk_rd && byte_cnt == '0)
					block_type <= type_in;
				if (byte_step) begin
					byte_cnt <= byte_cnt + 1'b1;
					if (last_byte)
						block_end <= 1'b1;
				end
			end
		end
	end

	// Payload size from the file header
	always_ff @(posedge clk) begin
		if (ce && disk_rd && block_type == fds_pkg::BLK_FILE_HEADER) begin
			if (byte_cnt == fds_pkg::SIZE_LO_IDX)
				file_size[7:0] <= prg_dbus;
			if (byte_cnt == fds_pkg::SIZE_HI_IDX)
				file_size[15:8] <= prg_dbus;
		end
	end

endmodule

// File: src/fds_mapper.sv
// FDS mapper top

`timescale 1ns/1ps

module fds_mapper (
	input  logic               clk,
	input  logic               diskreset,
	input  logic               ce,
	input  logic               prg_read,
	input  logic               prg_write,
	input  logic               fds_busy,
	input  logic               fds_eject_btn,
	input  logic               fds_fast,
	input  fds_pkg::cpu_addr_t prg_ain,
	input  fds_pkg::byte_t     prg_din,
	input  fds_pkg::byte_t     prg_dbus,
	input  fds_pkg::side_t     max_diskside,
	output fds_pkg::byte_t     prg_dout,
	output fds_pkg::mem_addr_t prg_aout,
	output logic               prg_allow,
	output logic               prg_bus_write,
	output logic               irq,
	output fds_pkg::side_t     diskside
);

	logic timer_lo_wr, timer_hi_wr, timer_ctrl_wr, io_en_wr;
	logic status_rd, disk_rd, xfer_start;
	logic motor_on, head_rewind, byte_transfer, disk_irq_en;
	logic timer_irq, disk_irq;
	logic byte_flag, byte_step, disk_end, disk_ready, eject;
	logic block_end;
	fds_pkg::byte_t     wdata;
	fds_pkg::byte_t     reg_dout;
	fds_pkg::disk_pos_t disk_pos;

	fds_cpu_regs i_fds_cpu_regs (
		.clk(clk), .diskreset(diskreset), .ce(ce),
		.prg_read(prg_read), .prg_write(prg_write),
		.prg_ain(prg_ain), .prg_din(prg_din),
		.timer_irq(timer_irq), .byte_flag(byte_flag), .disk_end(disk_end),
		.eject(eject), .disk_ready(disk_ready),
		.disk_pos(disk_pos), .diskside(diskside),
		.timer_lo_wr(timer_lo_wr), .timer_hi_wr(timer_hi_wr),
		.timer_ctrl_wr(timer_ctrl_wr), .io_en_wr(io_en_wr),
		.status_rd(status_rd), .disk_rd(disk_rd), .xfer_start(xfer_start),
		.motor_on(motor_on), .head_rewind(head_rewind),
		.byte_transfer(byte_transfer), .disk_irq_en(disk_irq_en),
		.wdata(wdata), .prg_dout(reg_dout), .prg_aout(prg_aout),
		.prg_allow(prg_allow), .prg_bus_write(prg_bus_write)
	);

	fds_timer_irq i_fds_timer_irq (
		.clk(clk), .diskreset(diskreset), .ce(ce),
		.timer_lo_wr(timer_lo_wr), .timer_hi_wr(timer_hi_wr),
		.timer_ctrl_wr(timer_ctrl_wr), .io_en_wr(io_en_wr),
		.status_rd(status_rd), .wdata(wdata),
		.timer_irq(timer_irq)
	);

	fds_disk_drive i_fds_disk_drive (
		.clk(clk), .diskreset(diskreset), .ce(ce),
		.motor_on(motor_on), .head_rewind(head_rewind),
		.byte_transfer(byte_transfer), .disk_irq_en(disk_irq_en),
		.xfer_start(xfer_start), .disk_rd(disk_rd), .status_rd(status_rd),
		.block_end(block_end), .fds_busy(fds_busy), .fds_fast(fds_fast),
		.fds_eject_btn(fds_eject_btn), .max_diskside(max_diskside),
		.byte_flag(byte_flag), .byte_step(byte_step), .disk_end(disk_end),
		.disk_ready(disk_ready), .eject(eject), .disk_irq(disk_irq),
		.disk_pos(disk_pos), .diskside(diskside)
	);

	fds_block_tracker i_fds_block_tracker (
		.clk(clk), .diskreset(diskreset), .ce(ce),
		.xfer_start(xfer_start), .disk_rd(disk_rd), .byte_step(byte_step),
		.prg_dbus(prg_dbus),
		.block_end(block_end)
	);

	// $4031 returns the image byte fetched at prg_aout
	assign prg_dout = (prg_ain == fds_pkg::REG_DISK_DATA) ? prg_dbus : reg_dout;
	assign irq      = timer_irq | disk_irq;

endmodule

// File: testbench/tb_fds_mapper.sv
// FDS mapper testbench

`timescale 1ns/1ps

module tb_fds_mapper;

	localparam int CLK_PERIOD   = 100;
	localparam int IMG_SIZE     = 1 << 18;
	localparam int MAX_RELOAD   = 16 + 255;
	localparam int BYTE_WAIT    = int'(fds_pkg::BYTE_DELAY_FAST) + 20;
	localparam int PRE_GAP_WAIT = int'(fds_pkg::PRE_GAP_FAST) + BYTE_WAIT;
	localparam int MAX_READS    = 64;
	localparam int WATCHDOG_CYCLES = 2 * PRE_GAP_WAIT + MAX_READS * BYTE_WAIT
	                               + 12 * MAX_RELOAD + 5000;

	logic               clk = 1'b0;
	logic               diskreset, ce, prg_read, prg_write;
	logic               fds_busy, fds_eject_btn, fds_fast;
	fds_pkg::cpu_addr_t prg_ain;
	fds_pkg::byte_t     prg_din, prg_dbus, prg_dout;
	fds_pkg::side_t     max_diskside, diskside;
	fds_pkg::mem_addr_t prg_aout, exp_addr;
	logic               prg_allow, prg_bus_write, irq;

	fds_pkg::byte_t     image [0:IMG_SIZE-1]; // Disk image model
	integer             seed;
	longint             cyc, irq_cyc, t0;
	fds_pkg::side_t     exp_side;
	fds_pkg::disk_pos_t exp_pos, blk_last;
	logic               blk_done;
	logic               rd_bus_write; // prg_bus_write seen during the last read
	fds_pkg::timer_t    reload;
	fds_pkg::byte_t     d, size_n;

	fds_mapper i_fds_mapper (
		.clk(clk), .diskreset(diskreset), .ce(ce),
		.prg_read(prg_read), .prg_write(prg_write),
		.fds_busy(fds_busy), .fds_eject_btn(fds_eject_btn), .fds_fast(fds_fast),
		.prg_ain(prg_ain), .prg_din(prg_din), .prg_dbus(prg_dbus),
		.max_diskside(max_diskside), .prg_dout(prg_dout), .prg_aout(prg_aout),
		.prg_allow(prg_allow), .prg_bus_write(prg_bus_write),
		.irq(irq), .diskside(diskside)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	always @(posedge clk) cyc <= cyc + 1;

	// Image bytes only answer in the disk window
	assign prg_dbus = (prg_aout[21:18] == fds_pkg::DISK_IMAGE_BASE) ? image[prg_aout[17:0]]
	                                                              : 8'h00;

	function automatic int img_index(input fds_pkg::side_t side, input fds_pkg::disk_pos_t pos);
		return fds_pkg::SIDE_HEADER + fds_pkg::SIDE_BYTES * side + pos;
	endfunction

	function automatic fds_pkg::mem_addr_t ref_disk_addr(input fds_pkg::side_t side,
	                                                     input fds_pkg::disk_pos_t pos);
		return {fds_pkg::DISK_IMAGE_BASE, 18'(img_index(side, pos))};
	endfunction

	function automatic fds_pkg::byte_t ref_disk_byte(input fds_pkg::side_t side,
	                                                 input fds_pkg::disk_pos_t pos);
		return image[img_index(side, pos)];
	endfunction

	// BIOS sits at the bottom and the 32K work RAM window at $8000
	function automatic fds_pkg::mem_addr_t ref_prg_addr(input fds_pkg::cpu_addr_t addr);
		if (addr >= 16'hE000)
			return 22'(addr - 16'hE000);
		return 22'h8000 + 22'(addr[14:0]);
	endfunction

	// Last position of the block at start using the file size in the header at hdr
	function automatic fds_pkg::disk_pos_t ref_block_last(input fds_pkg::side_t side,
	                                                      input fds_pkg::disk_pos_t start,
	                                                      input fds_pkg::disk_pos_t hdr);
		fds_pkg::byte_t     kind;
		fds_pkg::disk_pos_t size;
		kind = ref_disk_byte(side, start);
		size = {ref_disk_byte(side, hdr + 16'd14), ref_disk_byte(side, hdr + 16'd13)};
		case (kind[2:0])
			3'd1:    return start + 16'h0037;
			3'd2:    return start + 16'h0001;
			3'd3:    return start + 16'h000F;
			3'd4:    return start + size;
			default: return 16'hFFFF;
		endcase
	endfunction

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("TESTS FAILED");
		$fatal(1, "Simulation stopped");
	endtask

	task automatic check_equal(input string what, input int got, input int exp);
		assert (got == exp) else
			abort_run($sformatf("[FAIL] %0d ns: %s is %0d, expected %0d", $time, what, got, exp));
	endtask

	// Every $4031 read is held against the model
	always @(negedge clk) begin
		if (!diskreset && prg_read && prg_ain == fds_pkg::REG_DISK_DATA) begin
			exp_addr = ref_disk_addr(exp_side, exp_pos);
			assert (prg_aout == exp_addr) else
				abort_run($sformatf("[FAIL] %0d ns: disk address %h, expected %h",
				                    $time, prg_aout, exp_addr));
			assert (prg_dout == ref_disk_byte(exp_side, exp_pos)) else
				abort_run($sformatf("[FAIL] %0d ns: disk byte %h, expected %h",
				                    $time, prg_dout, ref_disk_byte(exp_side, exp_pos)));
		end
	end

	task automatic cpu_write(input fds_pkg::cpu_addr_t addr, input fds_pkg::byte_t data);
		@(posedge clk);
		prg_ain   <= addr;
		prg_din   <= data;
		prg_write <= 1'b1;
		@(posedge clk);
		prg_write <= 1'b0;
	endtask

	task automatic cpu_read(input fds_pkg::cpu_addr_t addr, output fds_pkg::byte_t data);
		@(posedge clk);
		prg_ain  <= addr;
		prg_read <= 1'b1;
		@(negedge clk);
		data = prg_dout;
		rd_bus_write = prg_bus_write;
		@(posedge clk);
		prg_read <= 1'b0;
	endtask

	// Memory access through the PRG window
	task automatic check_prg_map(input fds_pkg::cpu_addr_t addr, input logic wr);
		logic allow;
		@(posedge clk);
		prg_ain   <= addr;
		prg_read  <= ~wr;
		prg_write <= wr;
		@(negedge clk);
		allow = (addr >= 16'h6000 && addr < 16'hE000) || (addr >= 16'hE000 && !wr);
		check_equal("PRG address", prg_aout, ref_prg_addr(addr));
		check_equal("prg_allow", prg_allow, allow);
		check_equal("prg_bus_write on memory", prg_bus_write, 0);
		@(posedge clk);
		prg_read  <= 1'b0;
		prg_write <= 1'b0;
	endtask

	task automatic wait_irq(input int limit);
		int n;
		n = 0;
		@(negedge clk);
		while (!irq) begin
			n++;
			if (n > limit)
				abort_run($sformatf("No interrupt arrived within %0d cycles", limit));
			@(negedge clk);
		end
		irq_cyc = cyc;
	endtask

	task automatic expect_irq_low(input int cycles);
		repeat (cycles) begin
			@(negedge clk);
			check_equal("irq", irq, 0);
		end
	endtask

	task automatic start_block(input fds_pkg::disk_pos_t hdr);
		blk_done = 1'b0;
		blk_last = ref_block_last(exp_side, exp_pos, hdr);
	endtask

	// Reads the pending byte and moves the model head
	task automatic take_disk_byte();
		fds_pkg::byte_t data;
		cpu_read(fds_pkg::REG_DISK_DATA, data);
		@(posedge clk); // Byte counted here
		if (!blk_done) begin
			if (exp_pos == blk_last)
				blk_done = 1'b1;
			exp_pos++;
		end
	endtask

	task automatic read_disk_byte(input int limit);
		wait_irq(limit);
		take_disk_byte();
	endtask

	task automatic press_eject();
		@(posedge clk);
		fds_eject_btn <= 1'b1;
		repeat (3) @(posedge clk);
		fds_eject_btn <= 1'b0;
		exp_side = (exp_side == max_diskside) ? 2'd0 : exp_side + 2'd1;
		@(negedge clk);
		check_equal("diskside", diskside, exp_side);
	endtask

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		abort_run($sformatf("Timeout, the run did not end within %0d cycles", WATCHDOG_CYCLES));
	end

	initial begin
		seed          = 32'h3928;
		cyc           = 0;
		exp_side      = 2'd0;
		exp_pos       = 16'd0;
		diskreset     = 1'b1;
		ce            = 1'b1;
		prg_read      = 1'b0;
		prg_write     = 1'b0;
		prg_ain       = 16'h0000;
		prg_din       = 8'h00;
		fds_busy      = 1'b0;
		fds_eject_btn = 1'b0;
		fds_fast      = 1'b1;
		max_diskside  = 2'd2;

		for (int i = 0; i < IMG_SIZE; i++)
			image[i] = $random(seed);
		// Side 0 opens with a file header and its data block
		size_n = 8'd4 + 8'($random(seed) & 7);
		image[img_index(0, 0)]  = 8'h03;
		image[img_index(0, 13)] = size_n;
		image[img_index(0, 14)] = 8'h00;
		image[img_index(0, 16)] = 8'h04;

		repeat (5) @(posedge clk);
		diskreset <= 1'b0;
		@(negedge clk);
		check_equal("irq after reset", irq, 0);
		check_equal("diskside after reset", diskside, 0);

		// PRG translation for BIOS and work RAM
		check_prg_map(16'hE123, 1'b0);
		check_prg_map(16'hE123, 1'b1);
		check_prg_map(16'h6456, 1'b1);
		check_prg_map(16'hC789, 1'b0);

		// One-shot timer
		reload = 16'd16 + 16'($random(seed) & 255);
		cpu_write(fds_pkg::REG_IO_EN, 8'h01);
		cpu_write(fds_pkg::REG_TIMER_LO, reload[7:0]);
		cpu_write(fds_pkg::REG_TIMER_HI, reload[15:8]);
		cpu_write(fds_pkg::REG_TIMER_CTRL, 8'h02);
		@(negedge clk);
		t0 = cyc;
		wait_irq(MAX_RELOAD + 10);
		check_equal("one-shot delay", int'(irq_cyc - t0), reload + 1);
		cpu_read(fds_pkg::REG_STATUS, d);
		check_equal("$4030 timer bit", d[0], 1);
		check_equal("prg_bus_write on $4030", rd_bus_write, 1);
		@(posedge clk);
		expect_irq_low(reload + 5);

		// Repeat timer over three periods
		reload = 16'd16 + 16'($random(seed) & 255);
		cpu_write(fds_pkg::REG_TIMER_LO, reload[7:0]);
		cpu_write(fds_pkg::REG_TIMER_HI, reload[15:8]);
		cpu_write(fds_pkg::REG_TIMER_CTRL, 8'h03);
		@(negedge clk);
		t0 = cyc;
		for (int k = 0; k < 3; k++) begin
			wait_irq(MAX_RELOAD + 10);
			check_equal("repeat period", int'(irq_cyc - t0), reload + 1);
			t0 = irq_cyc;
			cpu_read(fds_pkg::REG_STATUS, d);
			@(posedge clk);
		end
		cpu_write(fds_pkg::REG_IO_EN, 8'h00);
		expect_irq_low(2 * (reload + 1));

		// Header block read to its end with motor, transfer and IRQ on
		cpu_write(fds_pkg::REG_DISK_CTRL, 8'hC1);
		start_block(16'd0);
		wait_irq(PRE_GAP_WAIT);
		cpu_read(fds_pkg::REG_STATUS, d);
		check_equal("$4030 byte ready bit", d[7], 1);
		take_disk_byte();
		while (!blk_done)
			read_disk_byte(BYTE_WAIT);
		repeat (3) read_disk_byte(BYTE_WAIT); // Head parked at the block end

		// New transfer over the data block of size_n bytes
		cpu_write(fds_pkg::REG_DISK_CTRL, 8'h81);
		cpu_write(fds_pkg::REG_DISK_CTRL, 8'hC1);
		start_block(16'd0);
		while (!blk_done)
			read_disk_byte(BYTE_WAIT);
		repeat (2) read_disk_byte(BYTE_WAIT);

		// Rewind
		cpu_write(fds_pkg::REG_DISK_CTRL, 8'hC3);
		repeat (2) @(posedge clk);
		cpu_read(fds_pkg::REG_DRIVE_STATUS, d);
		check_equal("$4032 not ready in rewind", d[1], 1);
		cpu_write(fds_pkg::REG_DISK_CTRL, 8'h81);
		cpu_read(fds_pkg::REG_DRIVE_STATUS, d);
		check_equal("$4032 not ready after rewind", d[1], 0);
		cpu_write(fds_pkg::REG_DISK_CTRL, 8'hC1);
		exp_pos = 16'd0;
		start_block(16'd0);
		read_disk_byte(PRE_GAP_WAIT);

		// Side switching wraps after max_diskside
		for (int k = 0; k < 3; k++) begin
			press_eject();
			cpu_read(fds_pkg::REG_DRIVE_STATUS, d);
			check_equal("$4032 eject bits", d & 8'h05, 8'h05);
			read_disk_byte(BYTE_WAIT);
		end

		$display("TESTS PASSED");
		$finish;
	end

endmodule

// File: sim.f
src/fds_pkg.sv
src/fds_cpu_regs.sv
src/fds_timer_irq.sv
src/fds_disk_drive.sv
src/fds_block_tracker.sv
src/fds_mapper.sv
testbench/tb_fds_mapper.sv

// File: Bender.yml
package:
  name: fds_mapper

sources:
  - files:
      - src/fds_pkg.sv
      - src/fds_cpu_regs.sv
      - src/fds_timer_irq.sv
      - src/fds_disk_drive.sv
      - src/fds_block_tracker.sv
      - src/fds_mapper.sv
  - target: simulation
    files:
      - testbench/tb_fds_mapper.sv
